//--- rtl/cpu_pkg.sv
package cpu_pkg;

    typedef logic [7:0]  data_t;    // one byte on the internal bus
    typedef logic [15:0] addr_t;    // rom and ram address
    typedef logic [2:0]  op_sel_t;  // hi_rom[7:5]
    typedef logic [4:0]  dev_sel_t; // destination device
    typedef logic [2:0]  alu_op_t;  // lo_rom[2:0]

    typedef enum logic [1:0] {PH_RESET, PH_FETCH, PH_EXEC} phase_t;

    // operation field
    localparam op_sel_t OP_ROM      = 3'd0; // immediate from lo_rom
    localparam op_sel_t OP_RAM      = 3'd1; // ram at mar
    localparam op_sel_t OP_RAM_ZP   = 3'd2; // ram at zero page lo_rom
    localparam op_sel_t OP_STORE_ZP = 3'd3; // x via alu passx into zero page
    localparam op_sel_t OP_ALU_ZX   = 3'd4;
    localparam op_sel_t OP_ALU_REG  = 3'd5;
    localparam op_sel_t OP_UART     = 3'd6;
    localparam op_sel_t OP_UART_ZP  = 3'd7;

    // low device group
    localparam dev_sel_t DEV_RAM     = 5'd0;
    localparam dev_sel_t DEV_MARLO   = 5'd1;
    localparam dev_sel_t DEV_MARHI   = 5'd2;
    localparam dev_sel_t DEV_UART    = 5'd3;
    localparam dev_sel_t DEV_PCHITMP = 5'd4;
    localparam dev_sel_t DEV_PCLO    = 5'd5;
    localparam dev_sel_t DEV_PC      = 5'd6;
    localparam dev_sel_t DEV_JMPO    = 5'd7;
    // high device group, all conditional jumps
    localparam dev_sel_t DEV_JMPZ    = 5'd8;
    localparam dev_sel_t DEV_JMPC    = 5'd9;
    localparam dev_sel_t DEV_JMPDI   = 5'd10;
    localparam dev_sel_t DEV_JMPDO   = 5'd11;
    localparam dev_sel_t DEV_JMPEQ   = 5'd12;
    localparam dev_sel_t DEV_JMPNE   = 5'd13;
    localparam dev_sel_t DEV_JMPGT   = 5'd14;
    localparam dev_sel_t DEV_JMPLT   = 5'd15;

    localparam alu_op_t ALU_PASSX = 3'd0;
    localparam alu_op_t ALU_ADD   = 3'd1;
    localparam alu_op_t ALU_SUB   = 3'd2;
    localparam alu_op_t ALU_AND   = 3'd3;
    localparam alu_op_t ALU_OR    = 3'd4;
    localparam alu_op_t ALU_XOR   = 3'd5;
    localparam alu_op_t ALU_PASSY = 3'd6;
    localparam alu_op_t ALU_INCX  = 3'd7;

endpackage : cpu_pkg

//--- rtl/ctrl_bus_if.sv
`timescale 1ns/100ps

interface ctrl_bus_if;
    // source strobes, active low
    logic rom_out_n;
    logic ram_out_n;
    logic alu_out_n;
    logic uart_out_n;
    // destination strobes, active low levels
    logic ram_in_n;
    logic marlo_in_n;
    logic marhi_in_n;
    logic uart_in_n;
    logic pchitmp_in_n; // hi tmp byte
    logic pclo_in_n;    // low pc byte only
    logic pc_in_n;      // full jump, already folded with flags
    logic reg_in_n;
    // alu overrides, active high
    logic force_alu_op_to_passx;
    logic force_x_val_to_zero;
    logic ram_zp_n; // zero page address from lo_rom

    modport decode (
        output rom_out_n, ram_out_n, alu_out_n, uart_out_n,
        output ram_in_n, marlo_in_n, marhi_in_n, uart_in_n,
        output pchitmp_in_n, pclo_in_n, pc_in_n, reg_in_n,
        output force_alu_op_to_passx, force_x_val_to_zero, ram_zp_n
    );

    modport sink (
        input rom_out_n, ram_out_n, alu_out_n, uart_out_n,
        input ram_in_n, marlo_in_n, marhi_in_n, uart_in_n,
        input pchitmp_in_n, pclo_in_n, pc_in_n, reg_in_n,
        input force_alu_op_to_passx, force_x_val_to_zero, ram_zp_n
    );

endinterface : ctrl_bus_if

//--- rtl/control_decode.sv
`timescale 1ns/100ps

module control_decode (
    ctrl_bus_if.decode     ctrl,
    input cpu_pkg::data_t  hi_rom,
    input logic [6:0]      flags_n,  // z c o eq ne gt lt from msb down
    input logic            uart_in_ready_n,
    input logic            uart_out_ready_n
);
    import cpu_pkg::*;

    op_sel_t  op;
    dev_sel_t dev;
    logic     dev_is_reg;
    logic     flag_z_n, flag_c_n, flag_o_n;
    logic     flag_eq_n, flag_ne_n, flag_gt_n, flag_lt_n;
    logic     jmpo_n, jmpz_n, jmpc_n, jmpdi_n, jmpdo_n;
    logic     jmpeq_n, jmpne_n, jmpgt_n, jmplt_n;

    assign op = hi_rom[7:5];
    assign {flag_z_n, flag_c_n, flag_o_n, flag_eq_n, flag_ne_n, flag_gt_n, flag_lt_n} = flags_n;

    // bit 4 belongs to the alu on the zero-x op, so it never reaches a register
    assign dev        = {hi_rom[0] && (op != OP_ALU_ZX), hi_rom[4:1]};
    assign dev_is_reg = dev[4];

    // source strobes
    assign ctrl.rom_out_n  = !(op == OP_ROM);
    assign ctrl.ram_out_n  = !(op == OP_RAM || op == OP_RAM_ZP);
    assign ctrl.alu_out_n  = !(op == OP_STORE_ZP || op == OP_ALU_ZX || op == OP_ALU_REG);
    assign ctrl.uart_out_n = !(op == OP_UART || op == OP_UART_ZP);

    // zp ops take the ram address from lo_rom
    assign ctrl.ram_zp_n = !(op == OP_RAM_ZP || op == OP_STORE_ZP || op == OP_UART_ZP);

    assign ctrl.force_x_val_to_zero   = (op == OP_ALU_ZX);
    assign ctrl.force_alu_op_to_passx = (op == OP_STORE_ZP); // lo_rom is the address here

    // register write
    always_comb begin
        ctrl.reg_in_n = !(
            (!ctrl.rom_out_n && dev_is_reg) ||
            (!ctrl.ram_out_n && dev_is_reg) ||
            (op == OP_ALU_REG) ||   // always lands in x or y
            (op == OP_UART && dev_is_reg)
        );
    end

    // zp stores always hit ram, never while ram drives the bus
    assign ctrl.ram_in_n = ((dev != DEV_RAM) && (op != OP_STORE_ZP) && (op != OP_UART_ZP))
                           || !ctrl.ram_out_n;
    assign ctrl.marlo_in_n   = (dev != DEV_MARLO);
    assign ctrl.marhi_in_n   = (dev != DEV_MARHI);
    assign ctrl.uart_in_n    = (dev != DEV_UART);
    assign ctrl.pchitmp_in_n = (dev != DEV_PCHITMP);
    assign ctrl.pclo_in_n    = (dev != DEV_PCLO);

    // each jump fires only with its flag low
    assign jmpo_n  = (dev != DEV_JMPO)  || flag_o_n;
    assign jmpz_n  = (dev != DEV_JMPZ)  || flag_z_n;
    assign jmpc_n  = (dev != DEV_JMPC)  || flag_c_n;
    assign jmpdi_n = (dev != DEV_JMPDI) || uart_in_ready_n;  // rx byte waiting
    assign jmpdo_n = (dev != DEV_JMPDO) || uart_out_ready_n; // tx can accept
    assign jmpeq_n = (dev != DEV_JMPEQ) || flag_eq_n;
    assign jmpne_n = (dev != DEV_JMPNE) || flag_ne_n;
    assign jmpgt_n = (dev != DEV_JMPGT) || flag_gt_n;
    assign jmplt_n = (dev != DEV_JMPLT) || flag_lt_n;

    // unconditional or any taken jump
    assign ctrl.pc_in_n = (dev != DEV_PC) && jmpo_n && jmpz_n && jmpc_n && jmpdi_n &&
                          jmpdo_n && jmpeq_n && jmpne_n && jmpgt_n && jmplt_n;

    // only one driver on the data bus
    always_comb begin
        assert final ($countones({!ctrl.rom_out_n, !ctrl.ram_out_n,
                                  !ctrl.alu_out_n, !ctrl.uart_out_n}) <= 1)
            else $error("more than one bus source selected");
    end

endmodule : control_decode

//--- rtl/phase_sequencer.sv
`timescale 1ns/100ps

module phase_sequencer (
    input  logic             clk,
    input  logic             rst,
    output cpu_pkg::phase_t  phase,
    output logic             exec_en
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= PH_RESET;
        end else begin
            case (phase)
                PH_RESET: phase <= PH_FETCH; // one idle cycle after release
                PH_FETCH: phase <= PH_EXEC;
                PH_EXEC:  phase <= PH_FETCH;
                default:  phase <= PH_RESET;
            endcase
        end
    end

    // write qualifier for every data module
    assign exec_en = (phase == PH_EXEC);

    // two clocks per instruction
    a_exec_then_fetch: assert property (
        @(posedge clk) disable iff (rst)
        (phase == PH_EXEC) |=> (phase == PH_FETCH)
    ) else $error("exec not followed by fetch");

endmodule : phase_sequencer

//--- rtl/program_counter.sv
`timescale 1ns/100ps

module program_counter (
    input  logic            clk,
    input  logic            rst,
    input  logic            exec_en,
    ctrl_bus_if.sink        ctrl,
    input  cpu_pkg::data_t  bus,
    output cpu_pkg::addr_t  pc
);

    logic [7:0] pc_hi_tmp; // staged high byte for the next jump

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_hi_tmp <= '0;
        end else if (exec_en && !ctrl.pchitmp_in_n) begin
            pc_hi_tmp <= bus;
        end
    end

    // pc only moves on the edge that ends exec
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (exec_en) begin
            if (!ctrl.pc_in_n) begin
                pc <= {pc_hi_tmp, bus}; // jump with hi from tmp
            end else if (!ctrl.pclo_in_n) begin
                pc <= {pc[15:8], bus};  // low byte only
            end else begin
                pc <= pc + 16'd1;
            end
        end
    end

endmodule : program_counter

//--- rtl/alu_regs.sv
`timescale 1ns/100ps

module alu_regs (
    input  logic            clk,
    input  logic            rst,
    input  logic            exec_en,
    ctrl_bus_if.sink        ctrl,
    input  cpu_pkg::data_t  hi_rom,
    input  cpu_pkg::data_t  lo_rom,
    input  cpu_pkg::data_t  bus,
    output cpu_pkg::data_t  alu_out,
    output logic [6:0]      flags_n, // z c o eq ne gt lt, msb first
    output cpu_pkg::data_t  x,
    output cpu_pkg::data_t  y
);
    import cpu_pkg::*;

    data_t      x_val;  // x operand after force-zero
    alu_op_t    op;
    logic [8:0] res;    // bit 8 is carry, or borrow on sub
    logic       ovf;
    logic [6:0] flags;

    assign x_val = ctrl.force_x_val_to_zero ? 8'h00 : x;
    assign op    = ctrl.force_alu_op_to_passx ? ALU_PASSX : lo_rom[2:0];

    always_comb begin
        res = {1'b0, x_val}; // pass x
        ovf = 1'b0;
        case (op)
            ALU_ADD: begin
                res = {1'b0, x_val} + {1'b0, y};
                ovf = (x_val[7] == y[7]) && (res[7] != x_val[7]);
            end
            ALU_SUB: begin
                res = {1'b0, x_val} - {1'b0, y};
                ovf = (x_val[7] != y[7]) && (res[7] != x_val[7]);
            end
            ALU_AND:   res = {1'b0, x_val & y};
            ALU_OR:    res = {1'b0, x_val | y};
            ALU_XOR:   res = {1'b0, x_val ^ y};
            ALU_PASSY: res = {1'b0, y};
            ALU_INCX: begin
                res = {1'b0, x_val} + 9'd1;
                ovf = (x_val == 8'h7f);  // +127 wraps negative
            end
            default: res = {1'b0, x_val};
        endcase
    end

    assign alu_out = res[7:0];

    // flags only follow alu ops
    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (exec_en && !ctrl.alu_out_n) begin
            flags <= {res[7:0] == 8'h00, res[8], ovf,
                      x_val == y, x_val != y, x_val > y, x_val < y}; // unsigned compare
        end
    end

    assign flags_n = ~flags;

    // device low bit picks y
    always_ff @(posedge clk) begin
        if (rst) begin
            x <= '0;
            y <= '0;
        end else if (exec_en && !ctrl.reg_in_n) begin
            if (hi_rom[1]) begin
                y <= bus;
            end else begin
                x <= bus;
            end
        end
    end

endmodule : alu_regs

//--- rtl/data_memory.sv
`timescale 1ns/100ps

module data_memory #(
    parameter int RAM_ADDR_W = 10
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            exec_en,
    ctrl_bus_if.sink        ctrl,
    input  cpu_pkg::data_t  lo_rom,
    input  cpu_pkg::data_t  alu_out,
    input  cpu_pkg::data_t  uart_rx_data,
    output cpu_pkg::data_t  bus,
    output logic            uart_tx_strobe,
    output logic            uart_rx_ack
);
    import cpu_pkg::*;

    data_t                 marlo, marhi;
    addr_t                 full_addr;
    logic [RAM_ADDR_W-1:0] ram_addr; // wraps at ram depth
    data_t                 ram [2**RAM_ADDR_W];
    data_t                 ram_rd;

    always_ff @(posedge clk) begin
        if (rst) begin
            marlo <= '0;
            marhi <= '0;
        end else if (exec_en) begin
            if (!ctrl.marlo_in_n) marlo <= bus;
            if (!ctrl.marhi_in_n) marhi <= bus;
        end
    end

    // zero page ignores the mar entirely
    assign full_addr = ctrl.ram_zp_n ? {marhi, marlo} : {8'h00, lo_rom};
    assign ram_addr  = full_addr[RAM_ADDR_W-1:0];
    assign ram_rd    = ram[ram_addr];

    always_ff @(posedge clk) begin
        if (exec_en && !ctrl.ram_in_n) ram[ram_addr] <= bus;
    end

    always_comb begin
        if (!ctrl.rom_out_n)       bus = lo_rom; // immediate
        else if (!ctrl.ram_out_n)  bus = ram_rd;
        else if (!ctrl.alu_out_n)  bus = alu_out;
        else if (!ctrl.uart_out_n) bus = uart_rx_data;
        else                       bus = 8'h00;
    end

    // single pulse in exec
    assign uart_tx_strobe = exec_en && !ctrl.uart_in_n;
    assign uart_rx_ack    = exec_en && !ctrl.uart_out_n;

    // decoder must never read and write ram in one exec
    a_no_ram_rw: assert property (
        @(posedge clk) disable iff (rst)
        exec_en |-> !(!ctrl.ram_in_n && !ctrl.ram_out_n)
    ) else $error("ram written while sourcing the bus");

endmodule : data_memory

//--- rtl/cpu_top.sv
`timescale 1ns/100ps

module cpu_top #(
    parameter int RAM_ADDR_W = 10
) (
    input  logic            clk,
    input  logic            rst,
    output cpu_pkg::addr_t  pc,                // rom address
    input  cpu_pkg::data_t  hi_rom,
    input  cpu_pkg::data_t  lo_rom,
    input  cpu_pkg::data_t  uart_rx_data,
    input  logic            uart_in_ready_n,
    output logic            uart_rx_ack,
    output cpu_pkg::data_t  uart_tx_data,
    output logic            uart_tx_strobe,
    input  logic            uart_out_ready_n,
    output cpu_pkg::data_t  dbg_x,
    output cpu_pkg::data_t  dbg_y,
    output logic [6:0]      dbg_flags          // active low z c o eq ne gt lt
);
    import cpu_pkg::*;

    logic   exec_en;
    data_t  bus;
    data_t  alu_out;

    ctrl_bus_if ctrl ();

    assign uart_tx_data = bus; // tx byte is whatever drives the bus

    control_decode i_decode (.ctrl(ctrl.decode), .hi_rom(hi_rom), .flags_n(dbg_flags),
        .uart_in_ready_n(uart_in_ready_n), .uart_out_ready_n(uart_out_ready_n));

    phase_sequencer i_seq (.clk(clk), .rst(rst), .phase(), .exec_en(exec_en));

    program_counter i_pc (.clk(clk), .rst(rst), .exec_en(exec_en), .ctrl(ctrl.sink),
        .bus(bus), .pc(pc));

    alu_regs i_alu (.clk(clk), .rst(rst), .exec_en(exec_en), .ctrl(ctrl.sink),
        .hi_rom(hi_rom), .lo_rom(lo_rom), .bus(bus), .alu_out(alu_out),
        .flags_n(dbg_flags), .x(dbg_x), .y(dbg_y));

    data_memory #(.RAM_ADDR_W(RAM_ADDR_W)) i_mem (.clk(clk), .rst(rst), .exec_en(exec_en),
        .ctrl(ctrl.sink), .lo_rom(lo_rom), .alu_out(alu_out), .uart_rx_data(uart_rx_data),
        .bus(bus), .uart_tx_strobe(uart_tx_strobe), .uart_rx_ack(uart_rx_ack));

endmodule : cpu_top

//--- dv/cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int       RAM_AW    = 10;
    localparam int       MAX_CYC   = 20000; // watchdog limit in clocks
    localparam dev_sel_t DEV_REG_X = 5'd16;
    localparam dev_sel_t DEV_REG_Y = 5'd17;

    logic       clk;
    logic       rst;
    addr_t      pc;
    data_t      hi_rom;
    data_t      lo_rom;
    data_t      uart_rx_data;
    logic       uart_in_ready_n;
    logic       uart_rx_ack;
    data_t      uart_tx_data;
    logic       uart_tx_strobe;
    logic       uart_out_ready_n;
    data_t      dbg_x;
    data_t      dbg_y;
    logic [6:0] dbg_flags;

    logic [15:0] rom [65536];       // {hi, lo} per pc
    data_t       m_ram [2**RAM_AW]; // model ram
    addr_t       m_pc;
    data_t       m_x, m_y, m_pchi, m_marlo, m_marhi;
    logic [6:0]  m_flags;           // active high z c o eq ne gt lt
    addr_t       cur_pc;            // state the dut should show right now
    data_t       cur_x, cur_y;
    logic [6:0]  cur_flags;
    logic        in_exec, exp_tx, exp_ack, check_en;
    data_t       exp_tx_data;
    data_t       tx_log [$];        // bytes seen on the uart tx side
    int          errors, checks, test_errs, tests;

    cpu_top #(.RAM_ADDR_W(RAM_AW)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // hard stop so a stuck program cannot hang the run
    initial begin
        repeat (MAX_CYC) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", MAX_CYC);
        $display("*** FAILED ***");
        $finish;
    end

    always @(negedge clk) begin
        if (!rst && uart_tx_strobe) tx_log.push_back(uart_tx_data); // uart model logs tx side
    end

    task automatic check_val(input string what, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // compare process samples mid cycle where everything is settled
    always @(negedge clk) begin
        if (check_en) begin
            check_val("pc", pc, cur_pc);
            check_val("x", dbg_x, cur_x);
            check_val("y", dbg_y, cur_y);
            check_val("flags_n", dbg_flags, {9'd0, ~cur_flags});
            check_val("uart_tx_strobe", uart_tx_strobe, in_exec && exp_tx);
            check_val("uart_rx_ack", uart_rx_ack, in_exec && exp_ack);
            if (in_exec && exp_tx) check_val("uart_tx_data", uart_tx_data, exp_tx_data);
        end
    end

    function automatic data_t enc(input op_sel_t op, input dev_sel_t dev);
        return {op, dev[3:0], dev[4]}; // bit 0 extends dev to the register bank
    endfunction

    function automatic data_t fill_byte(input int a);
        return data_t'(a) ^ data_t'((a >> 8) * 8'h35) ^ 8'hc3;
    endfunction

    // reference model of one whole instruction from the pre-exec state
    function automatic void cpu_step(input data_t hi, input data_t lo, input data_t rx,
                                     input logic in_rdy_n, input logic out_rdy_n,
                                     output logic tx_v, output data_t tx_d, output logic ack);
        op_sel_t    op;
        dev_sel_t   dev;
        logic       zp, take, ov;
        logic       fz, fc, fo, feq, fne, fgt, flt;
        int         a, sx, sy, s;
        data_t      xo, b;
        logic [8:0] r;

        op  = hi[7:5];
        dev = {hi[0] && (op != OP_ALU_ZX), hi[4:1]}; // zero-x op never reaches x or y
        zp  = op inside {OP_RAM_ZP, OP_STORE_ZP, OP_UART_ZP};
        if (zp) a = lo;
        else a = int'({m_marhi, m_marlo}) % (2**RAM_AW); // ram wraps
        xo  = (op == OP_ALU_ZX) ? 8'h00 : m_x;
        sx  = $signed(xo);
        sy  = $signed(m_y);
        ov  = 1'b0;
        case ((op == OP_STORE_ZP) ? ALU_PASSX : lo[2:0])
            ALU_ADD: begin
                r  = xo + m_y;
                s  = sx + sy;
                ov = (s > 127) || (s < -128);
            end
            ALU_SUB: begin
                r  = {xo < m_y, data_t'(xo - m_y)}; // bit 8 is the borrow
                s  = sx - sy;
                ov = (s > 127) || (s < -128);
            end
            ALU_AND:   r = xo & m_y;
            ALU_OR:    r = xo | m_y;
            ALU_XOR:   r = xo ^ m_y;
            ALU_PASSY: r = m_y;
            ALU_INCX: begin
                r  = xo + 1;
                ov = (sx + 1 > 127);
            end
            default:   r = xo;
        endcase
        case (op)
            OP_ROM:              b = lo;
            OP_RAM, OP_RAM_ZP:   b = m_ram[a];
            OP_UART, OP_UART_ZP: b = rx;
            default:             b = r[7:0];
        endcase
        {fz, fc, fo, feq, fne, fgt, flt} = m_flags; // jumps see the old flags
        case (dev)
            DEV_PC:    take = 1'b1;
            DEV_JMPO:  take = fo;
            DEV_JMPZ:  take = fz;
            DEV_JMPC:  take = fc;
            DEV_JMPDI: take = !in_rdy_n;
            DEV_JMPDO: take = !out_rdy_n;
            DEV_JMPEQ: take = feq;
            DEV_JMPNE: take = fne;
            DEV_JMPGT: take = fgt;
            DEV_JMPLT: take = flt;
            default:   take = 1'b0;
        endcase
        tx_v = (dev == DEV_UART);
        tx_d = b;
        ack  = (op == OP_UART) || (op == OP_UART_ZP);
        if (op inside {OP_STORE_ZP, OP_ALU_ZX, OP_ALU_REG})
            m_flags = {r[7:0] == 8'h00, r[8], ov, xo == m_y, xo != m_y, xo > m_y, xo < m_y};
        if ((dev == DEV_RAM || op == OP_STORE_ZP || op == OP_UART_ZP) &&
            !(op inside {OP_RAM, OP_RAM_ZP})) begin
            m_ram[a] = b;
        end
        if (op == OP_ALU_REG || (dev[4] && op inside {OP_ROM, OP_RAM, OP_RAM_ZP, OP_UART})) begin
            if (dev[0]) m_y = b;
            else m_x = b;
        end
        if (dev == DEV_MARLO) m_marlo = b;
        if (dev == DEV_MARHI) m_marhi = b;
        if (take) m_pc = {m_pchi, b};
        else if (dev == DEV_PCLO) m_pc = {m_pc[15:8], b};
        else m_pc = m_pc + 16'd1;
        if (dev == DEV_PCHITMP) m_pchi = b;
    endfunction

    // entered 5 ns into a fetch, leaves 5 ns into the next fetch
    task automatic run_instr(input data_t hi, input data_t lo);
        logic  tx_v, ack_v;
        data_t tx_d;
        rom[pc] = {hi, lo};
        {hi_rom, lo_rom} = rom[pc];
        cpu_step(hi, lo, uart_rx_data, uart_in_ready_n, uart_out_ready_n, tx_v, tx_d, ack_v);
        @(posedge clk);
        #5;
        in_exec     = 1'b1;
        exp_tx      = tx_v;
        exp_tx_data = tx_d;
        exp_ack     = ack_v;
        @(posedge clk);
        #5;
        in_exec   = 1'b0;
        cur_pc    = m_pc;
        cur_x     = m_x;
        cur_y     = m_y;
        cur_flags = m_flags;
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("test %0d %s done, %0d errors", tests, name, test_errs);
        test_errs = 0;
    endtask

    initial begin
        dev_sel_t cond_jmp [7] = '{DEV_JMPO, DEV_JMPZ, DEV_JMPC, DEV_JMPEQ,
                                   DEV_JMPNE, DEV_JMPGT, DEV_JMPLT};
        data_t    v, h;
        int       n, wait_n, ready_at;

        void'($urandom(32'hfc30a07b));
        rst = 1'b1;
        hi_rom = 8'h00;
        lo_rom = 8'h00;
        uart_rx_data = 8'h00;
        uart_in_ready_n = 1'b1;
        uart_out_ready_n = 1'b1;
        {errors, checks, test_errs, tests} = '0;
        {in_exec, exp_tx, exp_ack, check_en} = '0;
        exp_tx_data = 8'h00;
        {m_pc, m_x, m_y, m_pchi, m_marlo, m_marhi, m_flags} = '0;
        {cur_pc, cur_x, cur_y, cur_flags} = '0;
        @(posedge clk);
        #5;
        check_en = 1'b1; // pc and strobes must already be quiet in reset
        repeat (9) @(posedge clk);
        #5;
        rst = 1'b0;
        @(posedge clk); // the single PH_RESET cycle
        #5;

        for (n = 0; n < 4; n++) run_instr(enc(OP_ROM, DEV_MARLO), 8'(n));
        finish_test("reset");

        // whole ram gets a known byte, so later loads are never x
        for (int hb = 0; hb < 2**(RAM_AW-8); hb++) begin
            run_instr(enc(OP_ROM, DEV_MARHI), 8'(hb));
            for (int lb = 0; lb < 256; lb++) begin
                run_instr(enc(OP_ROM, DEV_MARLO), 8'(lb));
                run_instr(enc(OP_ROM, DEV_RAM), fill_byte(hb * 256 + lb));
            end
        end
        finish_test("ram_fill");

        for (n = 0; n < 24; n++) begin
            run_instr(enc(OP_ROM, DEV_REG_X), 8'($urandom));
            run_instr(enc(OP_ROM, DEV_REG_Y), 8'($urandom));
            if (n % 3 == 2) begin
                run_instr(enc(OP_ALU_ZX, DEV_REG_X), 8'($urandom)); // lands in ram at mar
            end else begin
                run_instr(enc(OP_ALU_REG, (n % 2) ? DEV_REG_Y : DEV_REG_X), 8'($urandom));
            end
        end
        finish_test("alu");

        for (n = 0; n < 6; n++) begin
            v = 8'($urandom);
            h = 8'($urandom); // zero page slot
            run_instr(enc(OP_ROM, DEV_REG_X), v);
            run_instr(enc(OP_STORE_ZP, DEV_RAM), h);
            run_instr(enc(OP_ROM, DEV_REG_X), ~v);
            run_instr(enc(OP_ROM, DEV_MARHI), 8'h00);
            run_instr(enc(OP_ROM, DEV_MARLO), h);
            run_instr(enc(OP_RAM, DEV_REG_Y), 8'h00);
            check_val("y after mar load", dbg_y, v);
            run_instr(enc(OP_RAM_ZP, DEV_REG_X), h);
            check_val("x after zero page load", dbg_x, v);
        end
        finish_test("memory");

        h = 8'($urandom);
        v = 8'($urandom);
        run_instr(enc(OP_ROM, DEV_PCHITMP), h);
        run_instr(enc(OP_ROM, DEV_PC), v);
        check_val("pc after jump", pc, {h, v});
        v = 8'($urandom);
        run_instr(enc(OP_ROM, DEV_PCLO), v);
        check_val("pc after pclo", pc, {h, v}); // high byte untouched
        for (n = 0; n < 28; n++) begin
            v = 8'($urandom);
            run_instr(enc(OP_ROM, DEV_REG_X), v);
            run_instr(enc(OP_ROM, DEV_REG_Y), (n % 4 == 0) ? v : 8'($urandom)); // some equal
            run_instr(enc(OP_ALU_REG, DEV_REG_X), 8'($urandom));
            run_instr(enc(OP_ROM, DEV_PCHITMP), 8'($urandom));
            run_instr(enc(OP_ROM, cond_jmp[n % 7]), 8'($urandom));
        end
        finish_test("jumps");

        uart_out_ready_n = 1'b0;
        run_instr(enc(OP_ROM, DEV_PCHITMP), 8'h12);
        run_instr(enc(OP_ROM, DEV_PC), 8'h00);
        v = 8'($urandom);
        uart_rx_data = v;
        ready_at = 4 + $urandom % 8;
        wait_n = 0;
        // poll loop at 0x1200, falls through to 0x1202 once a byte waits
        while (pc != 16'h1202 && wait_n < 64) begin
            if (wait_n == ready_at) uart_in_ready_n = 1'b0;
            if (pc == 16'h1200) run_instr(enc(OP_ROM, DEV_JMPDI), 8'h02);
            else run_instr(enc(OP_ROM, DEV_PC), 8'h00);
            wait_n++;
        end
        if (pc != 16'h1202) begin
            errors++;
            test_errs++;
            $display("uart receive poll loop never left 0x1200, rx ready was not seen");
        end
        run_instr(enc(OP_UART, DEV_REG_Y), 8'h00);
        check_val("rx byte in y", dbg_y, v);
        uart_in_ready_n = 1'b1;
        tx_log.delete();
        v = 8'($urandom);
        run_instr(enc(OP_ROM, DEV_UART), v);
        check_val("tx strobe count", tx_log.size(), 1);
        if (tx_log.size() == 1) check_val("tx byte", tx_log[0], v);
        finish_test("uart");

        for (n = 0; n < 200; n++) begin
            uart_in_ready_n  = 1'($urandom);
            uart_out_ready_n = 1'($urandom);
            uart_rx_data     = 8'($urandom);
            run_instr(8'($urandom), 8'($urandom)); // any op, any device
        end
        finish_test("random");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : cpu_tb

//--- filelist.f
rtl/cpu_pkg.sv
rtl/ctrl_bus_if.sv
rtl/control_decode.sv
rtl/phase_sequencer.sv
rtl/program_counter.sv
rtl/alu_regs.sv
rtl/data_memory.sv
rtl/cpu_top.sv
dv/cpu_tb.sv
